// ==== ex_stage.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_ctrl_if.sv
rtl/ex_control.sv
rtl/ex_operand_select.sv
rtl/ex_functional_unit.sv
rtl/ex_result_latch.sv
rtl/ex_stage.sv
test/ex_stage_assert.sv
test/ex_stage_tb.sv

// ==== rtl/ex_control.sv ====
// EX control; one CMPS pair in flight, enables are zeroed whenever the qualified valid bit is low
`timescale 1ns/1ps

module ex_control (
	input  logic              CLK,
	input  logic              rst_n,
	input  ex_pkg::uop_kind_t uop,
	input  logic              ex_valid,
	input  logic              repne,
	input  logic              repne_steady,
	input  logic              repne_terminate,
	input  logic              wb_stall,
	input  logic              de_ld_gpr1,
	input  logic              de_ld_gpr2,
	input  logic              de_dcache_write,
	input  ex_pkg::flags_t    alu_flags,
	ex_ctrl_if.ctrl           ctl,
	output logic              wb_valid_next,
	output logic              ld_gpr1_next,
	output logic              ld_gpr2_next,
	output logic              dcache_write_next,
	output logic              ex_ready
);
	import ex_pkg::*;
	`include "ex_params.svh"

	cmps_state_t cmps_state;
	cmps_state_t cmps_state_next;
	logic first_accept;
	logic second_accept;
	logic zf;
	logic valid_q;
	logic gpr1_dec;
	logic gpr2_dec;
	logic dcw_dec;

	assign ex_ready = ~wb_stall;
	assign first_accept = ex_valid & ~wb_stall & (uop == CMPS_FIRST);
	assign second_accept = ex_valid & ~wb_stall & (uop == CMPS_SECOND);

	// ----------------------------------------
	// CMPS pair FSM
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			cmps_state <= CMPS_IDLE;
		end else begin
			cmps_state <= cmps_state_next;
		end
	end

	always_comb begin
		cmps_state_next = cmps_state;
		case (cmps_state)
			CMPS_IDLE: begin
				if (first_accept) begin
					cmps_state_next = CMPS_PENDING;
				end
			end
			default: begin
				// a fresh first half just restarts the pair
				if (second_accept) begin
					cmps_state_next = CMPS_IDLE;
				end
			end
		endcase
	end

	// ----------------------------------------
	// select decode
	// ----------------------------------------
	always_comb begin
		ctl.cmps_capture    = first_accept;
		ctl.use_cmps_temp   = (uop == CMPS_SECOND) && (cmps_state == CMPS_PENDING);
		ctl.use_count_fwd   = repne_steady;
		ctl.pass_a          = (uop == PASS_A) || (uop == POP);
		ctl.swap_b_a        = (uop == XCHG) || (uop == CMPXCHG);
		ctl.take_a_as_b     = (uop == XCHG) || (uop == CMPS_FIRST);
		ctl.sp_pop          = (uop == POP);
		ctl.take_count_dec  = (uop == CMPS_SECOND);
		ctl.take_alu_result = (uop == ALU) || (uop == CMPS_SECOND);
		ctl.take_alu_flags  = (uop == ALU) || (uop == CMPS_SECOND) || (uop == CMPXCHG);
		ctl.take_c_as_a     = (uop == CMPXCHG);
		ctl.ld_latches      = ~wb_stall;
	end

	// cmpxchg writes the destination only on a match, else loads the accumulator
	always_comb begin
		zf = alu_flags[`EX_FLAG_ZF];
		gpr1_dec = de_ld_gpr1;
		gpr2_dec = de_ld_gpr2;
		dcw_dec = de_dcache_write;
		if (uop == CMPXCHG) begin
			gpr1_dec = de_ld_gpr1 & zf;
			gpr2_dec = ~zf;
			dcw_dec = de_dcache_write & zf;
		end
	end

	// repne iterations only retire on termination
	assign valid_q = repne ? (ex_valid & repne_terminate) : ex_valid;

	assign wb_valid_next = valid_q;
	assign ld_gpr1_next = gpr1_dec & valid_q;
	assign ld_gpr2_next = gpr2_dec & valid_q;
	assign dcache_write_next = dcw_dec & valid_q;

endmodule

// ==== rtl/ex_ctrl_if.sv ====
// EX select bundle; all signals are single-cycle combinational decodes of the current micro-op
`timescale 1ns/1ps

interface ex_ctrl_if;

	// operand side
	logic cmps_capture;
	logic use_cmps_temp;
	logic use_count_fwd;

	// result side
	logic pass_a;
	logic swap_b_a;
	logic take_a_as_b;
	logic sp_pop;
	logic take_count_dec;
	logic take_alu_result;
	logic take_alu_flags;
	logic take_c_as_a;
	logic ld_latches;

	modport ctrl (
		output cmps_capture, use_cmps_temp, use_count_fwd,
		output pass_a, swap_b_a, take_a_as_b, sp_pop, take_count_dec,
		output take_alu_result, take_alu_flags, take_c_as_a, ld_latches
	);

	modport dp (
		input cmps_capture, use_cmps_temp, use_count_fwd,
		input pass_a, swap_b_a, take_a_as_b, sp_pop, take_count_dec,
		input take_alu_result, take_alu_flags, take_c_as_a, ld_latches
	);

endinterface

// ==== rtl/ex_functional_unit.sv ====
// EX functional unit; sub-word ALU results are full 32-bit values, flags and shifts use the size
`timescale 1ns/1ps

module ex_functional_unit (
	input  ex_pkg::aluk_t     aluk,
	input  ex_pkg::datasize_t datasize,
	input  ex_pkg::pop_size_t pop_size,
	input  ex_pkg::word_t     a,
	input  ex_pkg::word_t     b,
	input  ex_pkg::word_t     b_sel,
	input  ex_pkg::word_t     c,
	input  ex_pkg::word_t     count,
	input  ex_pkg::flags_t    flags_in,
	output ex_pkg::word_t     alu_result,
	output ex_pkg::word_t     shift_result,
	output ex_pkg::word_t     count_dec,
	output ex_pkg::word_t     sp_pop,
	output ex_pkg::flags_t    alu_flags,
	output ex_pkg::flags_t    shift_flags
);
	import ex_pkg::*;
	`include "ex_params.svh"

	localparam aluk_t ALUK_ADD = 3'd0;
	localparam aluk_t ALUK_OR  = 3'd1;
	localparam aluk_t ALUK_ADC = 3'd2;
	localparam aluk_t ALUK_SBB = 3'd3;
	localparam aluk_t ALUK_AND = 3'd4;
	localparam aluk_t ALUK_SUB = 3'd5;
	localparam aluk_t ALUK_XOR = 3'd6;
	localparam aluk_t ALUK_CMP = 3'd7;

	word_t size_mask;
	logic [4:0] msb;
	logic is_sub;
	logic carry_in;
	word_t op_b;
	logic [8:0] sum8;
	logic [16:0] sum16;
	logic [32:0] sum32;
	logic logic_op;
	word_t flag_src;
	logic carry_out;
	logic [4:0] shamt;
	word_t shift_src;
	logic [63:0] left_wide;
	logic [32:0] right_wide;
	logic last_out;
	word_t pop_inc;

	// operand size view
	always_comb begin
		case (datasize)
			2'd0: begin
				size_mask = 32'h0000_00ff;
				msb = 5'd7;
			end
			2'd1: begin
				size_mask = 32'h0000_ffff;
				msb = 5'd15;
			end
			default: begin
				size_mask = 32'hffff_ffff;
				msb = 5'd31;
			end
		endcase
	end

	// ----------------------------------------
	// ALU
	// ----------------------------------------
	always_comb begin
		is_sub = (aluk == ALUK_SBB) || (aluk == ALUK_SUB) || (aluk == ALUK_CMP);
		carry_in = ((aluk == ALUK_ADC) || (aluk == ALUK_SBB)) & flags_in[`EX_FLAG_CF];
		// subtract as a + ~b + 1, borrow flips the carry
		op_b = is_sub ? ~b_sel : b_sel;
		carry_in = is_sub ? ~carry_in : carry_in;
		sum8 = {1'b0, a[7:0]} + {1'b0, op_b[7:0]} + {8'd0, carry_in};
		sum16 = {1'b0, a[15:0]} + {1'b0, op_b[15:0]} + {16'd0, carry_in};
		sum32 = {1'b0, a} + {1'b0, op_b} + {32'd0, carry_in};
		logic_op = 1'b1;
		case (aluk)
			ALUK_OR:  flag_src = a | b_sel;
			ALUK_AND: flag_src = a & b_sel;
			ALUK_XOR: flag_src = a ^ b_sel;
			default: begin
				flag_src = sum32[31:0];
				logic_op = 1'b0;
			end
		endcase
		case (datasize)
			2'd0: carry_out = sum8[8];
			2'd1: carry_out = sum16[16];
			default: carry_out = sum32[32];
		endcase
	end

	// cmp leaves the compared operand on the bus, only its flags matter
	assign alu_result = (aluk == ALUK_CMP) ? b_sel : flag_src;

	always_comb begin
		alu_flags = flags_in;
		alu_flags[`EX_FLAG_CF] = ~logic_op & (carry_out ^ is_sub);
		alu_flags[`EX_FLAG_ZF] = ((flag_src & size_mask) == '0);
		alu_flags[`EX_FLAG_SF] = flag_src[msb];
		alu_flags[`EX_FLAG_OF] = ~logic_op & (a[msb] == op_b[msb]) & (flag_src[msb] != a[msb]);
	end

	// ----------------------------------------
	// shifter
	// ----------------------------------------
	assign shamt = b[4:0];
	assign shift_src = a & size_mask;
	assign left_wide = {32'd0, shift_src} << shamt;
	assign right_wide = {shift_src, 1'b0} >> shamt;
	assign shift_result = aluk[0] ? right_wide[32:1] : (left_wide[31:0] & size_mask);
	assign last_out = aluk[0] ? right_wide[0] : left_wide[msb + 6'd1];

	// zero count leaves every flag alone
	always_comb begin
		shift_flags = flags_in;
		if (shamt != 5'd0) begin
			shift_flags[`EX_FLAG_CF] = last_out;
			shift_flags[`EX_FLAG_ZF] = (shift_result == '0);
			shift_flags[`EX_FLAG_SF] = shift_result[msb];
		end
	end

	// ----------------------------------------
	// count and stack arithmetic
	// ----------------------------------------
	assign count_dec = count - 32'd1;

	always_comb begin
		case (pop_size)
			2'd0: pop_inc = `EX_POP_2;
			2'd1: pop_inc = `EX_POP_4;
			2'd2: pop_inc = `EX_POP_8;
			default: pop_inc = `EX_POP_12;
		endcase
	end

	assign sp_pop = c + pop_inc;

endmodule

// ==== rtl/ex_operand_select.sv ====
// EX operand select; the saved CMPS operand survives stalls and only reloads on an accepted first half
`timescale 1ns/1ps

module ex_operand_select (
	input  logic          CLK,
	input  logic          rst_n,
	ex_ctrl_if.dp         ctl,
	input  ex_pkg::word_t a,
	input  ex_pkg::word_t b,
	input  ex_pkg::word_t c,
	input  ex_pkg::word_t count_fwd,
	output ex_pkg::word_t b_sel,
	output ex_pkg::word_t count
);
	import ex_pkg::*;

	word_t cmps_temp;

	// ----------------------------------------
	// string compare temporary
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			cmps_temp <= '0;
		end else if (ctl.cmps_capture) begin
			cmps_temp <= a;
		end
	end

	// second half compares against the first memory operand
	assign b_sel = ctl.use_cmps_temp ? cmps_temp : b;

	// steady repne takes the count straight from the forwarding path
	assign count = ctl.use_count_fwd ? count_fwd : c;

endmodule

// ==== rtl/ex_params.svh ====
// EX stage constants; flag positions follow the IA-32 EFLAGS layout, pop sizes are in bytes
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define EX_WORD_W 32
`define EX_ALUK_W 3
`define EX_SIZE_W 2

// eflags bit positions
`define EX_FLAG_CF 0
`define EX_FLAG_ZF 6
`define EX_FLAG_SF 7
`define EX_FLAG_OF 11

// stack increments, indexed by pop_size
`define EX_POP_2  32'd2
`define EX_POP_4  32'd4
`define EX_POP_8  32'd8
`define EX_POP_12 32'd12

`endif

// ==== rtl/ex_pkg.sv ====
// EX stage types; datasize 3 is not a legal size and is treated as 32 bit by the datapath
package ex_pkg;

	`include "ex_params.svh"

	// ----------------------------------------
	// data words
	// ----------------------------------------
	typedef logic [`EX_WORD_W-1:0] word_t;

	// full EFLAGS image, only CF ZF SF OF are computed here
	typedef logic [`EX_WORD_W-1:0] flags_t;

	// 0 add, 1 or, 2 adc, 3 sbb, 4 and, 5 sub, 6 xor, 7 cmp
	typedef logic [`EX_ALUK_W-1:0] aluk_t;

	// 0 byte, 1 word, 2 dword
	typedef logic [`EX_SIZE_W-1:0] datasize_t;

	// 0 -> 2, 1 -> 4, 2 -> 8, 3 -> 12 bytes
	typedef logic [`EX_SIZE_W-1:0] pop_size_t;

	// ----------------------------------------
	// micro-op kinds and FSM states
	// ----------------------------------------
	typedef enum logic [2:0] {
		ALU,
		SHIFT,
		PASS_A,
		XCHG,
		CMPXCHG,
		CMPS_FIRST,
		CMPS_SECOND,
		POP
	} uop_kind_t;

	// tracks the two halves of a string compare
	typedef enum logic {
		CMPS_IDLE,
		CMPS_PENDING
	} cmps_state_t;

endpackage

// ==== rtl/ex_result_latch.sv ====
// EX/WB register; only valid and the enables are reset, the payload is undefined until first load
`timescale 1ns/1ps

module ex_result_latch (
	input  logic           CLK,
	input  logic           rst_n,
	ex_ctrl_if.dp          ctl,
	input  ex_pkg::word_t  a,
	input  ex_pkg::word_t  b,
	input  ex_pkg::word_t  c,
	input  ex_pkg::word_t  alu_result,
	input  ex_pkg::word_t  shift_result,
	input  ex_pkg::word_t  count_dec,
	input  ex_pkg::word_t  sp_pop,
	input  ex_pkg::flags_t alu_flags,
	input  ex_pkg::flags_t shift_flags,
	input  logic           wb_valid_next,
	input  logic           ld_gpr1_next,
	input  logic           ld_gpr2_next,
	input  logic           dcache_write_next,
	output ex_pkg::word_t  wb_result_a,
	output ex_pkg::word_t  wb_result_b,
	output ex_pkg::word_t  wb_result_c,
	output ex_pkg::flags_t wb_flags,
	output logic           wb_valid,
	output logic           wb_ld_gpr1,
	output logic           wb_ld_gpr2,
	output logic           wb_dcache_write
);
	import ex_pkg::*;

	word_t result_a_next;
	word_t result_b_next;
	word_t result_c_next;
	flags_t flags_next;

	// ----------------------------------------
	// result select
	// ----------------------------------------
	// later selects win over earlier ones
	always_comb begin
		result_a_next = shift_result;
		if (ctl.take_c_as_a) begin
			result_a_next = c;
		end
		if (ctl.pass_a) begin
			result_a_next = a;
		end
		if (ctl.take_a_as_b) begin
			result_a_next = b;
		end
		if (ctl.take_alu_result) begin
			result_a_next = alu_result;
		end
		result_b_next = ctl.swap_b_a ? a : b;
		result_c_next = ctl.sp_pop ? sp_pop : c;
		if (ctl.take_count_dec) begin
			result_c_next = count_dec;
		end
		flags_next = ctl.take_alu_flags ? alu_flags : shift_flags;
	end

	// ----------------------------------------
	// pipeline register
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_ld_gpr1 <= 1'b0;
			wb_ld_gpr2 <= 1'b0;
			wb_dcache_write <= 1'b0;
		end else if (ctl.ld_latches) begin
			wb_valid <= wb_valid_next;
			wb_ld_gpr1 <= ld_gpr1_next;
			wb_ld_gpr2 <= ld_gpr2_next;
			wb_dcache_write <= dcache_write_next;
		end
	end

	always_ff @(posedge CLK) begin
		if (ctl.ld_latches) begin
			wb_result_a <= result_a_next;
			wb_result_b <= result_b_next;
			wb_result_c <= result_c_next;
			wb_flags <= flags_next;
		end
	end

endmodule

// ==== rtl/ex_stage.sv ====
// EX stage top; upstream must hold every input while ex_ready is low, results appear one clock later
`timescale 1ns/1ps

module ex_stage (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              ex_valid,
	input  ex_pkg::uop_kind_t uop,
	input  ex_pkg::aluk_t     aluk,
	input  ex_pkg::datasize_t datasize,
	input  ex_pkg::pop_size_t pop_size,
	input  ex_pkg::word_t     a,
	input  ex_pkg::word_t     b,
	input  ex_pkg::word_t     c,
	input  ex_pkg::word_t     count_fwd,
	input  ex_pkg::flags_t    flags_in,
	input  logic              repne,
	input  logic              repne_steady,
	input  logic              repne_terminate,
	input  logic              de_ld_gpr1,
	input  logic              de_ld_gpr2,
	input  logic              de_dcache_write,
	input  logic              wb_stall,
	output logic              ex_ready,
	output ex_pkg::word_t     wb_result_a,
	output ex_pkg::word_t     wb_result_b,
	output ex_pkg::word_t     wb_result_c,
	output ex_pkg::flags_t    wb_flags,
	output logic              wb_valid,
	output logic              wb_ld_gpr1,
	output logic              wb_ld_gpr2,
	output logic              wb_dcache_write
);
	import ex_pkg::*;

	ex_ctrl_if ctl_bus ();

	word_t b_sel;
	word_t count;
	word_t alu_result;
	word_t shift_result;
	word_t count_dec;
	word_t sp_pop;
	flags_t alu_flags;
	flags_t shift_flags;
	logic wb_valid_next;
	logic ld_gpr1_next;
	logic ld_gpr2_next;
	logic dcache_write_next;

	ex_control u_control (
		.CLK(CLK), .rst_n(rst_n), .uop(uop), .ex_valid(ex_valid),
		.repne(repne), .repne_steady(repne_steady), .repne_terminate(repne_terminate),
		.wb_stall(wb_stall), .de_ld_gpr1(de_ld_gpr1), .de_ld_gpr2(de_ld_gpr2),
		.de_dcache_write(de_dcache_write), .alu_flags(alu_flags), .ctl(ctl_bus.ctrl),
		.wb_valid_next(wb_valid_next), .ld_gpr1_next(ld_gpr1_next),
		.ld_gpr2_next(ld_gpr2_next), .dcache_write_next(dcache_write_next),
		.ex_ready(ex_ready)
	);

	ex_operand_select u_operand_select (
		.CLK(CLK), .rst_n(rst_n), .ctl(ctl_bus.dp), .a(a), .b(b), .c(c),
		.count_fwd(count_fwd), .b_sel(b_sel), .count(count)
	);

	ex_functional_unit u_functional_unit (
		.aluk(aluk), .datasize(datasize), .pop_size(pop_size), .a(a), .b(b),
		.b_sel(b_sel), .c(c), .count(count), .flags_in(flags_in),
		.alu_result(alu_result), .shift_result(shift_result), .count_dec(count_dec),
		.sp_pop(sp_pop), .alu_flags(alu_flags), .shift_flags(shift_flags)
	);

	ex_result_latch u_result_latch (
		.CLK(CLK), .rst_n(rst_n), .ctl(ctl_bus.dp), .a(a), .b(b), .c(c),
		.alu_result(alu_result), .shift_result(shift_result), .count_dec(count_dec),
		.sp_pop(sp_pop), .alu_flags(alu_flags), .shift_flags(shift_flags),
		.wb_valid_next(wb_valid_next), .ld_gpr1_next(ld_gpr1_next),
		.ld_gpr2_next(ld_gpr2_next), .dcache_write_next(dcache_write_next),
		.wb_result_a(wb_result_a), .wb_result_b(wb_result_b), .wb_result_c(wb_result_c),
		.wb_flags(wb_flags), .wb_valid(wb_valid), .wb_ld_gpr1(wb_ld_gpr1),
		.wb_ld_gpr2(wb_ld_gpr2), .wb_dcache_write(wb_dcache_write)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the EX stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f ex_stage.f \
	--top-module ex_stage_tb \
	-o Vex_stage_tb

out=$(./obj_dir/Vex_stage_tb)
echo "$out"

# the testbench prints the pass message only when every check passed
grep -qx "Test OK" <<< "$out"

// ==== test/ex_stage_assert.sv ====
// EX stage assertions; the stall hold rule assumes the payload was loaded at least once
`timescale 1ns/1ps

module ex_stage_assert (
	input logic           CLK,
	input logic           rst_n,
	input logic           wb_stall,
	input logic           wb_valid,
	input logic           wb_ld_gpr1,
	input logic           wb_ld_gpr2,
	input logic           wb_dcache_write,
	input ex_pkg::word_t  wb_result_a,
	input ex_pkg::word_t  wb_result_b,
	input ex_pkg::word_t  wb_result_c,
	input ex_pkg::flags_t wb_flags
);

	// failures of the checks below, summed up by the testbench
	int fail_count = 0;

	// ----------------------------------------
	// EX/WB register rules
	// ----------------------------------------
	property hold_on_stall;
		@(posedge CLK) disable iff (!rst_n)
		wb_stall |=> $stable({wb_result_a, wb_result_b, wb_result_c, wb_flags,
			wb_valid, wb_ld_gpr1, wb_ld_gpr2, wb_dcache_write});
	endproperty

	property enables_need_valid;
		@(posedge CLK) disable iff (!rst_n)
		!wb_valid |-> !(wb_ld_gpr1 || wb_ld_gpr2 || wb_dcache_write);
	endproperty

	// outputs are quiet while reset is held
	property idle_in_reset;
		@(posedge CLK) !rst_n |-> !(wb_valid || wb_ld_gpr1 || wb_ld_gpr2 || wb_dcache_write);
	endproperty

	hold_on_stall_a: assert property (hold_on_stall)
		else begin
			fail_count++;
			$error("EX/WB outputs changed while wb_stall was high");
		end
	enables_need_valid_a: assert property (enables_need_valid)
		else begin
			fail_count++;
			$error("load or write enable high without wb_valid");
		end
	idle_in_reset_a: assert property (idle_in_reset)
		else begin
			fail_count++;
			$error("EX/WB outputs active during reset");
		end

endmodule

bind ex_stage ex_stage_assert assert_i (.*);

// ==== test/ex_stage_tb.sv ====
// EX stage testbench; one micro-op in flight, expected values come from a model of the EX rules
`timescale 1ns/1ps

module ex_stage_tb;
	import ex_pkg::*;
	`include "ex_params.svh"

	typedef struct packed {
		uop_kind_t uop;
		aluk_t     aluk;
		datasize_t datasize;
		pop_size_t pop_size;
		word_t     a;
		word_t     b;
		word_t     c;
		word_t     count_fwd;
		flags_t    flags_in;
		logic      ex_valid;
		logic      repne;
		logic      repne_steady;
		logic      repne_terminate;
		logic      de_ld_gpr1;
		logic      de_ld_gpr2;
		logic      de_dcache_write;
	} op_t;

	typedef struct packed {
		word_t  a;
		word_t  b;
		word_t  c;
		flags_t flags;
		logic   valid;
		logic   gpr1;
		logic   gpr2;
		logic   dcw;
	} exp_t;

	logic CLK;
	logic rst_n;
	logic wb_stall;
	logic stall_on;
	logic ex_ready;
	op_t cur;
	int cur_tag;
	int last_tag;
	word_t wb_result_a;
	word_t wb_result_b;
	word_t wb_result_c;
	flags_t wb_flags;
	logic wb_valid;
	logic wb_ld_gpr1;
	logic wb_ld_gpr2;
	logic wb_dcache_write;

	// model state and bookkeeping
	logic cmps_pending;
	word_t cmps_saved;
	exp_t last_exp;
	logic have_last;
	logic hung;
	int checks;
	int errors;
	int ops_sent;
	int ops_seen;
	int test_num;
	int checks_start;
	int errors_start;

	ex_stage ex_stage_i (
		.CLK(CLK), .rst_n(rst_n), .ex_valid(cur.ex_valid), .uop(cur.uop),
		.aluk(cur.aluk), .datasize(cur.datasize), .pop_size(cur.pop_size),
		.a(cur.a), .b(cur.b), .c(cur.c), .count_fwd(cur.count_fwd),
		.flags_in(cur.flags_in), .repne(cur.repne), .repne_steady(cur.repne_steady),
		.repne_terminate(cur.repne_terminate), .de_ld_gpr1(cur.de_ld_gpr1),
		.de_ld_gpr2(cur.de_ld_gpr2), .de_dcache_write(cur.de_dcache_write),
		.wb_stall(wb_stall), .ex_ready(ex_ready), .wb_result_a(wb_result_a),
		.wb_result_b(wb_result_b), .wb_result_c(wb_result_c), .wb_flags(wb_flags),
		.wb_valid(wb_valid), .wb_ld_gpr1(wb_ld_gpr1), .wb_ld_gpr2(wb_ld_gpr2),
		.wb_dcache_write(wb_dcache_write)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// back-pressure from WB
	always @(posedge CLK) begin
		wb_stall <= stall_on && ($urandom_range(2, 0) == 0);
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic exp_t expect_result(op_t op, logic pending, word_t temp);
		exp_t e;
		word_t m;
		int msb;
		word_t bs;
		word_t src;
		word_t res;
		word_t sres;
		word_t inc;
		logic [32:0] wide;
		logic [63:0] lw;
		logic [4:0] sh;
		logic cin;
		logic cf;
		logic of;
		flags_t af;
		flags_t sfl;
		logic v;
		case (op.datasize)
			2'd0: begin
				m = 32'h0000_00ff;
				msb = 7;
			end
			2'd1: begin
				m = 32'h0000_ffff;
				msb = 15;
			end
			default: begin
				m = 32'hffff_ffff;
				msb = 31;
			end
		endcase
		bs = (op.uop == CMPS_SECOND && pending) ? temp : op.b;
		cin = (op.aluk == 3'd2 || op.aluk == 3'd3) ? op.flags_in[`EX_FLAG_CF] : 1'b0;
		cf = 1'b0;
		of = 1'b0;
		case (op.aluk)
			3'd1: res = op.a | bs;
			3'd4: res = op.a & bs;
			3'd6: res = op.a ^ bs;
			3'd0, 3'd2: begin
				res = op.a + bs + {31'd0, cin};
				wide = {1'b0, op.a & m} + {1'b0, bs & m} + {32'd0, cin};
				cf = wide > {1'b0, m};
				of = (op.a[msb] == bs[msb]) && (res[msb] != op.a[msb]);
			end
			default: begin
				// sbb, sub and cmp borrow
				res = op.a - bs - {31'd0, cin};
				cf = {1'b0, op.a & m} < ({1'b0, bs & m} + {32'd0, cin});
				of = (op.a[msb] != bs[msb]) && (res[msb] != op.a[msb]);
			end
		endcase
		af = op.flags_in;
		af[`EX_FLAG_CF] = cf;
		af[`EX_FLAG_ZF] = ((res & m) == 32'd0);
		af[`EX_FLAG_SF] = res[msb];
		af[`EX_FLAG_OF] = of;

		// shifter by b[4:0]
		sh = op.b[4:0];
		src = op.a & m;
		cf = 1'b0;
		if (op.aluk[0]) begin
			sres = src >> sh;
			if (sh != 5'd0) begin
				cf = src[sh - 5'd1];
			end
		end else begin
			lw = {32'd0, src} << sh;
			sres = lw[31:0] & m;
			cf = lw[msb + 1];
		end
		sfl = op.flags_in;
		if (sh != 5'd0) begin
			sfl[`EX_FLAG_CF] = cf;
			sfl[`EX_FLAG_ZF] = (sres == 32'd0);
			sfl[`EX_FLAG_SF] = sres[msb];
		end

		case (op.pop_size)
			2'd0: inc = `EX_POP_2;
			2'd1: inc = `EX_POP_4;
			2'd2: inc = `EX_POP_8;
			default: inc = `EX_POP_12;
		endcase

		case (op.uop)
			ALU, CMPS_SECOND: e.a = (op.aluk == 3'd7) ? bs : res;
			SHIFT: e.a = sres;
			PASS_A, POP: e.a = op.a;
			XCHG, CMPS_FIRST: e.a = op.b;
			default: e.a = op.c;
		endcase
		e.b = (op.uop == XCHG || op.uop == CMPXCHG) ? op.a : op.b;
		e.c = op.c;
		if (op.uop == POP) begin
			e.c = op.c + inc;
		end
		if (op.uop == CMPS_SECOND) begin
			e.c = (op.repne_steady ? op.count_fwd : op.c) - 32'd1;
		end
		e.flags = (op.uop == ALU || op.uop == CMPS_SECOND || op.uop == CMPXCHG) ? af : sfl;

		v = op.repne ? (op.ex_valid && op.repne_terminate) : op.ex_valid;
		e.valid = v;
		e.gpr1 = op.de_ld_gpr1 && v;
		e.gpr2 = op.de_ld_gpr2 && v;
		e.dcw = op.de_dcache_write && v;
		if (op.uop == CMPXCHG) begin
			e.gpr1 = op.de_ld_gpr1 && af[`EX_FLAG_ZF] && v;
			e.gpr2 = !af[`EX_FLAG_ZF] && v;
			e.dcw = op.de_dcache_write && af[`EX_FLAG_ZF] && v;
		end
		return e;
	endfunction

	function automatic op_t random_op(uop_kind_t kind);
		op_t op;
		op.uop = kind;
		op.aluk = aluk_t'($urandom_range(7, 0));
		op.datasize = datasize_t'($urandom_range(2, 0));
		op.pop_size = pop_size_t'($urandom_range(3, 0));
		op.a = $urandom;
		op.b = $urandom;
		op.c = $urandom;
		op.count_fwd = $urandom;
		op.flags_in = $urandom;
		op.ex_valid = 1'b1;
		op.repne = 1'b0;
		op.repne_steady = 1'b0;
		op.repne_terminate = 1'b0;
		op.de_ld_gpr1 = 1'b1;
		op.de_ld_gpr2 = 1'b0;
		op.de_dcache_write = 1'b0;
		return op;
	endfunction

	task automatic check_word(string name, word_t got, word_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, want);
		end
	endtask

	// ----------------------------------------
	// comparing process
	// ----------------------------------------
	initial begin : compare_outputs
		exp_t e;
		forever begin
			@(posedge CLK);
			if (rst_n && !wb_stall) begin
				e = expect_result(cur, cmps_pending, cmps_saved);
				if (cur.ex_valid && cur.uop == CMPS_FIRST) begin
					cmps_saved = cur.a;
					cmps_pending = 1'b1;
				end else if (cur.ex_valid && cur.uop == CMPS_SECOND) begin
					cmps_pending = 1'b0;
				end
				if (cur_tag != last_tag) begin
					ops_seen++;
					last_tag = cur_tag;
				end
				last_exp = e;
				have_last = 1'b1;
			end
			// stalled cycles compare against the held result
			@(negedge CLK);
			if (have_last && rst_n) begin
				check_word("wb_result_a", wb_result_a, last_exp.a);
				check_word("wb_result_b", wb_result_b, last_exp.b);
				check_word("wb_result_c", wb_result_c, last_exp.c);
				check_word("wb_flags", wb_flags, last_exp.flags);
				check_word("wb_valid", {31'd0, wb_valid}, {31'd0, last_exp.valid});
				check_word("wb_ld_gpr1", {31'd0, wb_ld_gpr1}, {31'd0, last_exp.gpr1});
				check_word("wb_ld_gpr2", {31'd0, wb_ld_gpr2}, {31'd0, last_exp.gpr2});
				check_word("wb_dcache_write", {31'd0, wb_dcache_write}, {31'd0, last_exp.dcw});
			end
		end
	end

	// hold the micro-op until an edge with ex_ready high takes it
	task automatic send_op(op_t op);
		int waited;
		logic done;
		if (!hung) begin
			cur <= op;
			cur_tag <= cur_tag + 1;
			ops_sent++;
			waited = 0;
			done = 1'b0;
			while (!done && waited < 50) begin
				@(posedge CLK);
				done = ex_ready;
				waited++;
			end
			if (!done) begin
				hung = 1'b1;
				$display("timeout: micro-op not accepted within 50 cycles");
			end
		end
	endtask

	task automatic start_test();
		test_num++;
		checks_start = checks;
		errors_start = errors;
	endtask

	// an invalid bubble follows the last micro-op so none is taken twice
	task automatic finish_test(string name);
		cur <= '0;
		@(negedge CLK);
		#1;
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - checks_start, errors - errors_start);
		@(posedge CLK);
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin : run_tests
		op_t op;
		op_t first;
		int i;
		void'($urandom(32'h4f23_e3f2));
		cur = '0;
		cur_tag = 0;
		last_tag = 0;
		rst_n = 1'b0;
		wb_stall = 1'b0;
		stall_on = 1'b0;
		cmps_pending = 1'b0;
		cmps_saved = '0;
		have_last = 1'b0;
		hung = 1'b0;
		checks = 0;
		errors = 0;
		ops_sent = 0;
		ops_seen = 0;
		test_num = 0;
		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;

		start_test();
		for (i = 0; i < 200; i++) begin
			send_op(random_op(($urandom_range(1, 0) == 0) ? ALU : SHIFT));
		end
		finish_test("alu and shift");

		start_test();
		for (i = 0; i < 24; i++) begin
			op = random_op((i % 3 == 0) ? PASS_A : ((i % 3 == 1) ? XCHG : POP));
			op.pop_size = pop_size_t'(i % 4);
			send_op(op);
		end
		finish_test("pass, xchg and pop");

		start_test();
		for (i = 0; i < 16; i++) begin
			first = random_op(CMPS_FIRST);
			send_op(first);
			op = random_op(CMPS_SECOND);
			op.aluk = 3'd7;
			op.a = ~first.a;
			op.repne_steady = i[0];
			op.repne = i[1];
			op.repne_terminate = i[2];
			send_op(op);
		end
		finish_test("cmps pair");

		start_test();
		for (i = 0; i < 20; i++) begin
			op = random_op(CMPXCHG);
			op.aluk = 3'd7;
			if (i[0]) begin
				op.b = op.a;
			end
			op.de_dcache_write = i[1];
			send_op(op);
		end
		finish_test("cmpxchg");

		start_test();
		stall_on <= 1'b1;
		for (i = 0; i < 120; i++) begin
			send_op(random_op(uop_kind_t'($urandom_range(7, 0))));
		end
		stall_on <= 1'b0;
		finish_test("stall stream");

		start_test();
		for (i = 0; i < 80; i++) begin
			op = random_op(uop_kind_t'($urandom_range(7, 0)));
			op.ex_valid = $urandom_range(1, 0) == 1;
			op.repne = $urandom_range(1, 0) == 1;
			op.repne_terminate = $urandom_range(1, 0) == 1;
			op.de_ld_gpr1 = $urandom_range(1, 0) == 1;
			op.de_ld_gpr2 = $urandom_range(1, 0) == 1;
			op.de_dcache_write = $urandom_range(1, 0) == 1;
			send_op(op);
		end
		finish_test("valid and repne");

		if (ops_seen != ops_sent) begin
			errors++;
			$display("micro-ops lost or duplicated: %0d sent, %0d seen", ops_sent, ops_seen);
		end
		if (ex_stage_i.assert_i.fail_count != 0) begin
			errors++;
			$display("bound assertions failed %0d times", ex_stage_i.assert_i.fail_count);
		end
		$display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0 && !hung) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
